/* common/sample_pkg.sv */
`default_nettype none

package sample_pkg;

	////////////////////////////////////////////////////////////
	// sample and beat formats
	////////////////////////////////////////////////////////////

	localparam int BLOCK_IDX_W = 4; // up to 16 blocks
	localparam int MEM_ADDR_W = 8; // 256 stored pairs max

	typedef logic signed [15:0] sample_t; // filtered sample

	// fifo and memory word, i in the upper half
	typedef struct packed {
		sample_t i;
		sample_t q;
	} iq_pair_t;

	typedef struct packed {
		iq_pair_t pair;
		logic [BLOCK_IDX_W-1:0] blk; // block index
		logic last; // final pair of the block
	} out_beat_t;

endpackage

`default_nettype wire

/* common/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		cap_idle = 2'd0, // waiting for a qualified edge
		cap_arming = 2'd1, // arm delay running
		cap_capturing = 2'd2, // pairs go into the fifo
		cap_wait_readback = 2'd3 // until the reader is finished
	} cap_state_t;

	localparam int CREDIT_W = 4;

	// output credits, also used for the in-flight reads
	typedef logic [CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

/* logic/stream_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
	parameter int DEPTH = 32
) (
	input wire logic phy_clk,
	input wire logic rst_n1,
	input wire logic push,
	input wire sample_pkg::iq_pair_t wr_pair,
	input wire logic pop,
	output sample_pkg::iq_pair_t rd_pair,
	output logic [$clog2(DEPTH+1)-1:0] count
);
	import sample_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH+1);

	iq_pair_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign rd_pair = mem[rd_ptr]; // head word

	always_ff @(posedge phy_clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_pair;
		end
	end

	always_ff @(posedge phy_clk or negedge rst_n1) begin
		if (!rst_n1) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1; // wrap
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		push |-> (count != CNT_W'(DEPTH)) || pop)
		else $error("fifo push while full");

	a_no_underflow: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		pop |-> count != '0)
		else $error("fifo pop while empty");

endmodule

`default_nettype wire

/* capture/capture_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl #(
	parameter int ARM_DELAY = 32,
	parameter int NUM_BLOCKS = 4,
	parameter int BURST_LEN = 16
) (
	input wire logic phy_clk,
	input wire logic rst_n1,
	input wire logic trigger,
	input wire sample_pkg::iq_pair_t in_pair,
	input wire logic in_valid,
	input wire logic readback_done,
	output logic push,
	output sample_pkg::iq_pair_t push_pair,
	output logic busy
);
	import ctrl_pkg::*;

	localparam int TOTAL = NUM_BLOCKS * BURST_LEN;
	localparam int ARM_W = $clog2(ARM_DELAY+1);
	localparam int PAIR_W = $clog2(TOTAL+1);

	logic trig_s1, trig_s2; // synchronizer
	logic trig_d1, trig_d2, trig_d3; // sample history
	logic edge_ok;
	cap_state_t state;
	logic [ARM_W-1:0] arm_cnt;
	logic [PAIR_W-1:0] pair_cnt;
	logic accept;

	////////////////////////////////////////////////////////////
	// trigger qualification for high high low low
	////////////////////////////////////////////////////////////

	always_ff @(posedge phy_clk or negedge rst_n1) begin
		if (!rst_n1) begin
			trig_s1 <= 1'b0;
			trig_s2 <= 1'b0;
			trig_d1 <= 1'b0;
			trig_d2 <= 1'b0;
			trig_d3 <= 1'b0;
		end else begin
			trig_s1 <= trigger;
			trig_s2 <= trig_s1;
			trig_d1 <= trig_s2;
			trig_d2 <= trig_d1;
			trig_d3 <= trig_d2;
		end
	end

	assign edge_ok = !trig_s2 && !trig_d1 && trig_d2 && trig_d3;

	////////////////////////////////////////////////////////////
	// capture sequencer
	////////////////////////////////////////////////////////////

	assign accept = (state == cap_capturing) && in_valid;
	assign busy = (state != cap_idle);

	always_ff @(posedge phy_clk or negedge rst_n1) begin
		if (!rst_n1) begin
			state <= cap_idle;
			arm_cnt <= '0;
			pair_cnt <= '0;
			push <= 1'b0;
		end else begin
			push <= accept;
			case (state)
				cap_idle: begin
					if (edge_ok) state <= cap_arming; // ignored while busy
					arm_cnt <= '0;
					pair_cnt <= '0;
				end
				cap_arming: begin
					arm_cnt <= arm_cnt + 1'b1;
					if (arm_cnt == ARM_W'(ARM_DELAY-1)) state <= cap_capturing;
				end
				cap_capturing: begin
					if (accept) begin
						pair_cnt <= pair_cnt + 1'b1;
						if (pair_cnt == PAIR_W'(TOTAL-1)) state <= cap_wait_readback;
					end
				end
				default: begin
					if (readback_done) state <= cap_idle;
				end
			endcase
		end
	end

	always_ff @(posedge phy_clk) begin
		push_pair <= in_pair;
	end

	// registered push may trail into wait_readback by one cycle
	a_push_in_capture: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		push |-> (state == cap_capturing) || (state == cap_wait_readback))
		else $error("push outside the capturing state");

endmodule

`default_nettype wire

/* store/sample_store.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_store #(
	parameter int BURST_LEN = 16,
	parameter int NUM_BLOCKS = 4
) (
	input wire logic phy_clk,
	input wire logic rst_n1,
	input wire logic [$clog2(2*BURST_LEN+1)-1:0] fifo_count,
	input wire sample_pkg::iq_pair_t fifo_pair,
	output logic pop,
	input wire logic [sample_pkg::MEM_ADDR_W-1:0] rd_addr,
	output sample_pkg::iq_pair_t rd_pair,
	output logic stored,
	input wire logic readback_done
);
	import sample_pkg::*;

	localparam int FCNT_W = $clog2(2*BURST_LEN+1);
	localparam int BEAT_W = $clog2(BURST_LEN+1);
	localparam int BLK_W = $clog2(NUM_BLOCKS+1);

	iq_pair_t mem [2**MEM_ADDR_W];
	logic [MEM_ADDR_W-1:0] wr_addr;
	logic [BEAT_W-1:0] beat_cnt;
	logic [BLK_W-1:0] blk_cnt;
	logic in_burst;
	logic burst_start;

	////////////////////////////////////////////////////////////
	// burst writer
	////////////////////////////////////////////////////////////

	assign burst_start = !in_burst && !stored && (fifo_count >= FCNT_W'(BURST_LEN));
	assign pop = in_burst; // one pair per burst cycle

	always_ff @(posedge phy_clk or negedge rst_n1) begin
		if (!rst_n1) begin
			in_burst <= 1'b0;
			beat_cnt <= '0;
			blk_cnt <= '0;
			wr_addr <= '0;
			stored <= 1'b0;
		end else if (readback_done) begin
			wr_addr <= '0; // rearm for the next capture
			blk_cnt <= '0;
			stored <= 1'b0;
		end else if (burst_start) begin
			in_burst <= 1'b1;
			beat_cnt <= '0;
		end else if (in_burst) begin
			wr_addr <= wr_addr + 1'b1;
			beat_cnt <= beat_cnt + 1'b1;
			if (beat_cnt == BEAT_W'(BURST_LEN-1)) begin
				in_burst <= 1'b0;
				blk_cnt <= blk_cnt + 1'b1;
				if (blk_cnt == BLK_W'(NUM_BLOCKS-1)) stored <= 1'b1; // all blocks in
			end
		end
	end

	////////////////////////////////////////////////////////////
	// sample memory
	////////////////////////////////////////////////////////////

	always_ff @(posedge phy_clk) begin
		if (in_burst) begin
			mem[wr_addr] <= fifo_pair;
		end
		rd_pair <= mem[rd_addr]; // one cycle read latency
	end

	a_pop_not_empty: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		pop |-> fifo_count != '0)
		else $error("store pops an empty fifo");

endmodule

`default_nettype wire

/* readback/block_reader.sv */
`timescale 1ns/100ps
`default_nettype none

module block_reader #(
	parameter int BURST_LEN = 16,
	parameter int NUM_BLOCKS = 4,
	parameter int OUT_CREDITS = 4
) (
	input wire logic phy_clk,
	input wire logic rst_n1,
	input wire logic stored,
	output logic [sample_pkg::MEM_ADDR_W-1:0] rd_addr,
	input wire sample_pkg::iq_pair_t rd_pair,
	output sample_pkg::out_beat_t out_beat,
	output logic out_valid,
	input wire logic credit_return,
	output logic readback_done
);
	import sample_pkg::*;
	import ctrl_pkg::*;

	localparam int BEAT_W = $clog2(BURST_LEN+1);

	credit_t credit_cnt; // beats the consumer can still take
	credit_t inflight; // reads not yet sent out
	logic [BEAT_W-1:0] beat_cnt;
	logic [BLOCK_IDX_W-1:0] blk_cnt;
	logic all_issued;
	logic issue;
	logic issue_last;
	logic s1_valid, s1_last; // memory read stage
	logic [BLOCK_IDX_W-1:0] s1_blk;

	assign issue = stored && !all_issued && (credit_cnt > inflight);
	assign issue_last = (beat_cnt == BEAT_W'(BURST_LEN-1));

	always_ff @(posedge phy_clk or negedge rst_n1) begin
		if (!rst_n1) begin
			rd_addr <= '0;
			beat_cnt <= '0;
			blk_cnt <= '0;
			all_issued <= 1'b0;
			credit_cnt <= credit_t'(OUT_CREDITS);
			inflight <= '0;
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
			readback_done <= 1'b0;
		end else begin
			if (readback_done) begin
				rd_addr <= '0;
				beat_cnt <= '0;
				blk_cnt <= '0;
				all_issued <= 1'b0;
			end else if (issue) begin
				rd_addr <= rd_addr + 1'b1;
				beat_cnt <= issue_last ? '0 : beat_cnt + 1'b1;
				if (issue_last) blk_cnt <= blk_cnt + 1'b1;
				if (issue_last && blk_cnt == BLOCK_IDX_W'(NUM_BLOCKS-1)) all_issued <= 1'b1;
			end
			case ({out_valid, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			case ({issue, out_valid})
				2'b10: inflight <= inflight + 1'b1;
				2'b01: inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
			s1_valid <= issue;
			out_valid <= s1_valid;
			readback_done <= out_valid && out_beat.last &&
				(out_beat.blk == BLOCK_IDX_W'(NUM_BLOCKS-1)); // pulse after final beat
		end
	end

	// markers ride along with the read, data joins one cycle later
	always_ff @(posedge phy_clk) begin
		s1_blk <= blk_cnt;
		s1_last <= issue_last;
		out_beat.pair <= rd_pair;
		out_beat.blk <= s1_blk;
		out_beat.last <= s1_last;
	end

	a_credit_bound: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		credit_cnt <= credit_t'(OUT_CREDITS))
		else $error("more credits returned than beats sent");

	a_valid_needs_credit: assert property (@(posedge phy_clk) disable iff (!rst_n1)
		out_valid |-> credit_cnt != '0)
		else $error("beat sent without credit");

endmodule

`default_nettype wire

/* logic/iq_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_capture_top #(
	parameter int BURST_LEN = 16,
	parameter int NUM_BLOCKS = 4,
	parameter int ARM_DELAY = 32,
	parameter int OUT_CREDITS = 4
) (
	input wire logic phy_clk,
	input wire logic rst_n1,
	input wire logic trigger, // async level
	input wire sample_pkg::iq_pair_t in_pair,
	input wire logic in_valid,
	output sample_pkg::out_beat_t out_beat,
	output logic out_valid,
	input wire logic credit_return,
	output logic busy
);
	import sample_pkg::*;

	localparam int FIFO_DEPTH = 2 * BURST_LEN;

	logic fifo_push;
	iq_pair_t fifo_wr_pair;
	logic fifo_pop;
	iq_pair_t fifo_head;
	logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
	logic [MEM_ADDR_W-1:0] mem_rd_addr;
	iq_pair_t mem_rd_pair;
	logic stored;
	logic readback_done;

	capture_ctrl #(.ARM_DELAY(ARM_DELAY), .NUM_BLOCKS(NUM_BLOCKS), .BURST_LEN(BURST_LEN))
	i_capture_ctrl (
		.phy_clk(phy_clk), .rst_n1(rst_n1), .trigger(trigger),
		.in_pair(in_pair), .in_valid(in_valid), .readback_done(readback_done),
		.push(fifo_push), .push_pair(fifo_wr_pair), .busy(busy)
	);

	stream_fifo #(.DEPTH(FIFO_DEPTH)) i_stream_fifo (
		.phy_clk(phy_clk), .rst_n1(rst_n1), .push(fifo_push), .wr_pair(fifo_wr_pair),
		.pop(fifo_pop), .rd_pair(fifo_head), .count(fifo_count)
	);

	sample_store #(.BURST_LEN(BURST_LEN), .NUM_BLOCKS(NUM_BLOCKS)) i_sample_store (
		.phy_clk(phy_clk), .rst_n1(rst_n1), .fifo_count(fifo_count),
		.fifo_pair(fifo_head), .pop(fifo_pop), .rd_addr(mem_rd_addr),
		.rd_pair(mem_rd_pair), .stored(stored), .readback_done(readback_done)
	);

	block_reader #(.BURST_LEN(BURST_LEN), .NUM_BLOCKS(NUM_BLOCKS), .OUT_CREDITS(OUT_CREDITS))
	i_block_reader (
		.phy_clk(phy_clk), .rst_n1(rst_n1), .stored(stored), .rd_addr(mem_rd_addr),
		.rd_pair(mem_rd_pair), .out_beat(out_beat), .out_valid(out_valid),
		.credit_return(credit_return), .readback_done(readback_done)
	);

endmodule

`default_nettype wire

/* verification/tb_iq_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_iq_capture;
	import sample_pkg::*;
	import ctrl_pkg::*;

	localparam int BURST_LEN = 16;
	localparam int NUM_BLOCKS = 4;
	localparam int ARM_DELAY = 32;
	localparam int OUT_CREDITS = 4;
	localparam int TOTAL = NUM_BLOCKS * BURST_LEN;
	localparam int CYCLE_LIMIT = 2 * TOTAL * 8 + 2 * ARM_DELAY + 500;

	logic phy_clk = 1'b0;
	logic rst_n1;
	logic trigger;
	iq_pair_t in_pair;
	logic in_valid;
	out_beat_t out_beat;
	logic out_valid;
	logic credit_return = 1'b0;
	logic busy;

	int captures_started = 0; // captures the checker may see
	int beats_seen = 0;
	credit_t owed_cnt = '0; // beats sent, credits not yet back
	int held = 0; // beats the consumer still holds
	int wait_cnt = 0;
	int cycle_cnt = 0;

	iq_capture_top #(
		.BURST_LEN(BURST_LEN),
		.NUM_BLOCKS(NUM_BLOCKS),
		.ARM_DELAY(ARM_DELAY),
		.OUT_CREDITS(OUT_CREDITS)
	) i_iq_capture_top (
		.phy_clk(phy_clk),
		.rst_n1(rst_n1),
		.trigger(trigger),
		.in_pair(in_pair),
		.in_valid(in_valid),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.credit_return(credit_return),
		.busy(busy)
	);

	always #2 phy_clk = ~phy_clk; // 4 ns period

	////////////////////////////////////////////////////////////
	// expected values and compare tasks
	////////////////////////////////////////////////////////////

	// pair n of a capture, counted from the first pair offered after arming
	function automatic iq_pair_t ref_pair(input int n);
		iq_pair_t p;
		p.i = sample_t'(n * 37 - 500);
		p.q = sample_t'(16'h4000 ^ (n * 11));
		return p;
	endfunction

	task automatic fail_now(input string what);
		$display("%s (time %0t)", what, $time);
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_pair(input string name, input iq_pair_t got, input iq_pair_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "pair mismatch");
		end
	endtask

	task automatic check_block(input string name, input logic [BLOCK_IDX_W-1:0] got,
		input logic [BLOCK_IDX_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "block index mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// consumer, checker and timeout
	////////////////////////////////////////////////////////////

	always @(posedge phy_clk) begin : consume_beats
		int next_held;
		next_held = held;
		credit_return <= 1'b0;
		if (!rst_n1) begin
			next_held = 0;
			wait_cnt <= 0;
		end else begin
			if (out_valid) next_held = next_held + 1;
			if (wait_cnt > 0) begin
				wait_cnt <= wait_cnt - 1; // consumer still busy
			end else if (held > 0) begin
				credit_return <= 1'b1;
				next_held = next_held - 1;
				wait_cnt <= $urandom_range(4, 0);
			end
		end
		held <= next_held;
	end

	always @(posedge phy_clk) begin : compare_beats
		int k;
		credit_t owed;
		if (rst_n1) begin
			owed = owed_cnt;
			if (out_valid) owed = owed + 1'b1;
			if (credit_return) owed = owed - 1'b1;
			if (owed > credit_t'(OUT_CREDITS)) begin
				fail_now("more beats outstanding than the consumer can hold");
			end
			owed_cnt <= owed;
			if (out_valid) begin
				if (beats_seen >= captures_started * TOTAL) begin
					fail_now("output beat appeared with no capture pending");
				end
				k = beats_seen % TOTAL;
				check_pair("out_beat.pair", out_beat.pair, ref_pair(k));
				check_block("out_beat.blk", out_beat.blk, BLOCK_IDX_W'(k / BURST_LEN));
				check_flag("out_beat.last", out_beat.last, (k % BURST_LEN) == BURST_LEN - 1);
				beats_seen <= beats_seen + 1;
			end
		end
	end

	always @(posedge phy_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			fail_now("timeout, the captures did not complete within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int num);
		repeat (num) @(posedge phy_clk);
	endtask

	task automatic trigger_pulse(input int high_cycles);
		@(posedge phy_clk);
		trigger <= 1'b1;
		repeat (high_cycles) @(posedge phy_clk);
		trigger <= 1'b0;
	endtask

	// random pairs while idle, none may be stored
	task automatic offer_noise(input int num);
		repeat (num) begin
			@(posedge phy_clk);
			check_flag("busy", busy, 1'b0);
			in_valid <= 1'b1;
			in_pair <= iq_pair_t'($urandom);
		end
		@(posedge phy_clk);
		in_valid <= 1'b0;
	endtask

	task automatic offer_pairs(input int first, input int num);
		int n;
		n = first;
		while (n < first + num) begin
			@(posedge phy_clk);
			if ($urandom_range(3, 0) != 0) begin
				in_valid <= 1'b1;
				in_pair <= ref_pair(n);
				n++;
			end else begin
				in_valid <= 1'b0; // input gap
			end
		end
		@(posedge phy_clk);
		in_valid <= 1'b0;
	endtask

	task automatic idle_check(input int num);
		repeat (num) begin
			@(posedge phy_clk);
			check_flag("busy", busy, 1'b0);
		end
	endtask

	task automatic wait_for_busy();
		int i;
		i = 0;
		while (!busy && i < 12) begin
			@(posedge phy_clk);
			i++;
		end
		if (!busy) fail_now("busy did not rise after a qualified trigger");
	endtask

	task automatic run_capture(input int target);
		trigger_pulse(2);
		wait_for_busy();
		wait_cycles(ARM_DELAY + 8); // arming window has passed
		offer_pairs(0, 24);
		check_flag("busy", busy, 1'b1);
		trigger_pulse(3); // must be ignored while busy
		offer_pairs(24, TOTAL - 24);
		while (beats_seen < target) @(posedge phy_clk);
		while (busy) @(posedge phy_clk);
		idle_check(20); // no second capture
	endtask

	initial begin
		void'($urandom(55861));
		rst_n1 = 1'b0;
		trigger = 1'b0;
		in_valid = 1'b0;
		in_pair = '0;
		repeat (16) @(posedge phy_clk);
		rst_n1 <= 1'b1;

		offer_noise(20);
		trigger_pulse(1); // single high sample
		idle_check(20);

		captures_started <= 1;
		run_capture(TOTAL);
		captures_started <= 2;
		run_capture(2 * TOTAL);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
common/sample_pkg.sv
common/ctrl_pkg.sv
logic/stream_fifo.sv
capture/capture_ctrl.sv
store/sample_store.sv
readback/block_reader.sv
logic/iq_capture_top.sv
verification/tb_iq_capture.sv

/* Makefile */
# Verilator build and run for the I/Q capture testbench

VERILATOR ?= verilator
TOP ?= tb_iq_capture
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST) --top-module $(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
